/* design/col_tagger.sv */
`timescale 1ns/100ps
`include "conv_params.svh"

module col_tagger (
    input  logic                        aclk,
    input  logic                        rst_n,
    input  logic                        aclken,
    input  logic                        start,
    input  conv_cfg_pkg::kernel_cfg_t   cfg,
    input  logic                        s_valid,
    input  logic                        s_last,
    output conv_stream_pkg::lane_beat_t tag_beat,
    output conv_cfg_pkg::kernel_cfg_t   act_cfg,
    output logic                        row_err
);

    import conv_cfg_pkg::*;
    import conv_stream_pkg::*;

    typedef enum logic {
        TAG_IDLE,
        TAG_RUN
    } tag_state_e;

    tag_state_e            state_q;
    logic [`COL_WIDTH-1:0] col_q;
    logic                  past_end_q; // the last column went by without s_last
    logic                  beat_ok;
    logic                  at_end;
    logic                  beat_valid_q;
    logic                  beat_last_q;
    pad_user_t             beat_user_q;

    // a beat in the same cycle as start belongs to no row and is dropped
    assign beat_ok = (state_q == TAG_RUN) && s_valid && !start;
    assign at_end  = (col_q == act_cfg.row_cols_1);

    // ==============================
    // row control
    // ==============================

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= TAG_IDLE;
            act_cfg    <= CFG_RESET;
            col_q      <= '0;
            past_end_q <= 1'b0;
            row_err    <= 1'b0;
        end else if (aclken) begin
            if (start) begin
                state_q    <= TAG_RUN;
                act_cfg    <= cfg;                // shadow copy for the coming rows
                col_q      <= '0;
                past_end_q <= 1'b0;
                row_err    <= 1'b0;
            end else if (beat_ok) begin
                if (s_last) begin
                    col_q      <= '0;
                    past_end_q <= 1'b0;
                end else begin
                    col_q <= col_q + 1'b1;
                    if (at_end) begin
                        past_end_q <= 1'b1;
                    end
                end
                // short row ends early, long row keeps going past its end
                if (past_end_q || (s_last && !at_end)) begin
                    row_err <= 1'b1;
                end
            end
        end
    end

    // ==============================
    // tagged beat
    // ==============================

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            beat_valid_q <= 1'b0;
            beat_last_q  <= 1'b0;
        end else if (aclken) begin
            beat_valid_q <= beat_ok;
            beat_last_q  <= beat_ok && s_last;
        end
    end

    always_ff @(posedge aclk) begin
        if (aclken && beat_ok) begin
            beat_user_q.col       <= col_q;
            beat_user_q.cols_left <= act_cfg.row_cols_1 - col_q; // wraps on an overlong row
        end
    end

    assign tag_beat = '{
        valid: beat_valid_q,
        last:  beat_last_q,
        user:  beat_user_q
    };

endmodule

/* design/conv_cfg_pkg.sv */
`include "conv_params.svh"

package conv_cfg_pkg;

    // register map of the configuration port
    typedef enum logic [1:0] {
        ADDR_KERNEL_W_1 = 2'd0,
        ADDR_MODE       = 2'd1,
        ADDR_ROW_COLS_1 = 2'd2,
        ADDR_CTRL       = 2'd3
    } cfg_addr_e;

    typedef enum logic {
        MODE_KXK = 1'b0, // full kernel, same padding
        MODE_1X1 = 1'b1  // pointwise, lane 0 only
    } conv_mode_e;

    // kernel and row geometry, both sizes stored minus one
    typedef struct packed {
        logic [`KW_WIDTH-1:0]  kernel_w_1;
        conv_mode_e            mode;
        logic [`COL_WIDTH-1:0] row_cols_1;
    } kernel_cfg_t;

    // 3 wide kernel over rows of 8 columns
    localparam kernel_cfg_t CFG_RESET = '{
        kernel_w_1: 'd2,
        mode:       MODE_KXK,
        row_cols_1: 'd7
    };

endpackage

/* design/conv_cfg_regs.sv */
`timescale 1ns/100ps
`include "conv_params.svh"

module conv_cfg_regs (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  logic                      aclken,
    input  logic                      cfg_wr,
    input  conv_cfg_pkg::cfg_addr_e   cfg_addr,
    input  logic [7:0]                cfg_wdata,
    output conv_cfg_pkg::kernel_cfg_t cfg,
    output logic                      start
);

    import conv_cfg_pkg::*;

    logic [`KW_WIDTH-1:0]  kernel_w_1_q;
    conv_mode_e            mode_q;
    logic [`COL_WIDTH-1:0] row_cols_1_q;
    logic                  wr_en;
    logic                  ctrl_go;

    assign wr_en   = aclken && cfg_wr;
    assign ctrl_go = cfg_wr && (cfg_addr == ADDR_CTRL) && cfg_wdata[0];

    // ==============================
    // configuration registers
    // ==============================

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            kernel_w_1_q <= CFG_RESET.kernel_w_1;
        end else if (wr_en && (cfg_addr == ADDR_KERNEL_W_1)) begin
            kernel_w_1_q <= cfg_wdata[`KW_WIDTH-1:0];
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q <= CFG_RESET.mode;
        end else if (wr_en && (cfg_addr == ADDR_MODE)) begin
            mode_q <= conv_mode_e'(cfg_wdata[0]);
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            row_cols_1_q <= CFG_RESET.row_cols_1;
        end else if (wr_en && (cfg_addr == ADDR_ROW_COLS_1)) begin
            row_cols_1_q <= cfg_wdata[`COL_WIDTH-1:0];
        end
    end

    // staging copy, the tagger takes its own snapshot on start
    assign cfg = '{
        kernel_w_1: kernel_w_1_q,
        mode:       mode_q,
        row_cols_1: row_cols_1_q
    };

    // ==============================
    // start pulse
    // ==============================

    // one enabled cycle wide, raised the cycle after the control write
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            start <= 1'b0;
        end else if (aclken) begin
            start <= ctrl_go;
        end
    end

endmodule

/* design/conv_pad_top.sv */
`timescale 1ns/100ps
`include "conv_params.svh"

module conv_pad_top (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  logic                      aclken,
    input  logic                      cfg_wr,
    input  conv_cfg_pkg::cfg_addr_e   cfg_addr,
    input  logic [7:0]                cfg_wdata,
    input  logic                      s_valid,
    input  logic                      s_last,
    output logic [`KERNEL_W_MAX-1:0]  snake_valid,
    output logic [`KERNEL_W_MAX-1:0]  m_valid,
    output logic [`KERNEL_W_MAX-1:0]  m_last,
    output logic                      row_err
);

    import conv_cfg_pkg::*;
    import conv_stream_pkg::*;

    kernel_cfg_t cfg;      // staging copy written over the register port
    kernel_cfg_t act_cfg;  // copy in use since the last start
    logic        start;
    lane_beat_t  tag_beat;

    // ==============================
    // register block
    // ==============================

    conv_cfg_regs i_regs (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .aclken    (aclken),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg),
        .start     (start)
    );

    // ==============================
    // tagger and filter
    // ==============================

    col_tagger i_tagger (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .aclken   (aclken),
        .start    (start),
        .cfg      (cfg),
        .s_valid  (s_valid),
        .s_last   (s_last),
        .tag_beat (tag_beat),
        .act_cfg  (act_cfg),
        .row_err  (row_err)
    );

    pad_filter i_filter (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .aclken      (aclken),
        .act_cfg     (act_cfg),
        .tag_beat    (tag_beat),
        .snake_valid (snake_valid),
        .m_valid     (m_valid),
        .m_last      (m_last)
    );

endmodule

/* design/conv_stream_pkg.sv */
`include "conv_params.svh"

package conv_stream_pkg;

    // ==============================
    // per-beat sideband
    // ==============================

    // position of a beat within its row
    typedef struct packed {
        logic [`COL_WIDTH-1:0] col;       // column index c
        logic [`COL_WIDTH-1:0] cols_left; // row width minus one, minus c
    } pad_user_t;

    // ==============================
    // one lane of the snake
    // ==============================

    typedef struct packed {
        logic      valid;
        logic      last;  // final beat of the row
        pad_user_t user;
    } lane_beat_t;

endpackage

/* design/pad_filter.sv */
`timescale 1ns/100ps
`include "conv_params.svh"

module pad_filter (
    input  logic                        aclk,
    input  logic                        rst_n,
    input  logic                        aclken,
    input  conv_cfg_pkg::kernel_cfg_t   act_cfg,
    input  conv_stream_pkg::lane_beat_t tag_beat,
    output logic [`KERNEL_W_MAX-1:0]    snake_valid,
    output logic [`KERNEL_W_MAX-1:0]    m_valid,
    output logic [`KERNEL_W_MAX-1:0]    m_last
);

    import conv_cfg_pkg::*;
    import conv_stream_pkg::*;

    localparam int NL = `KERNEL_W_MAX;

    logic [NL-1:0]        lane_valid_q;
    logic [NL-1:0]        lane_last_q;
    pad_user_t            lane_user_q [NL];
    logic [`KW_WIDTH-1:0] pad;         // P, columns of padding on each side
    logic [NL-1:0]        live;        // lane takes part in the current kernel
    logic [NL-1:0]        col_in_row;  // output column of the lane is inside the row

    // ==============================
    // lane snake
    // ==============================

    // lane k carries the beat k enabled cycles after lane 0
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            lane_valid_q <= '0;
            lane_last_q  <= '0;
        end else if (aclken) begin
            lane_valid_q <= {lane_valid_q[NL-2:0], tag_beat.valid};
            lane_last_q  <= {lane_last_q[NL-2:0], tag_beat.last};
        end
    end

    always_ff @(posedge aclk) begin
        if (aclken) begin
            lane_user_q[0] <= tag_beat.user;
            for (int k = 1; k < NL; k++) begin
                lane_user_q[k] <= lane_user_q[k-1];
            end
        end
    end

    // ==============================
    // padding masks
    // ==============================

    // same padding, P is half of kernel width minus one, none in 1x1 mode
    assign pad = (act_cfg.mode == MODE_1X1) ? '0 : (act_cfg.kernel_w_1 >> 1);

    always_comb begin
        for (int k = 0; k < NL; k++) begin
            if (act_cfg.mode == MODE_1X1) begin
                live[k] = (k == 0);
            end else begin
                live[k] = (k <= int'(act_cfg.kernel_w_1));
            end
            // output column c - k + P must land in 0 .. row width minus one
            col_in_row[k] = (k <= int'(lane_user_q[k].col) + int'(pad)) &&
                            (k + int'(lane_user_q[k].cols_left) >= int'(pad));
        end
    end

    assign snake_valid = lane_valid_q;
    assign m_valid     = lane_valid_q & live & col_in_row;
    assign m_last      = lane_last_q & live; // end of row reaches even masked lanes

endmodule

/* include/conv_params.svh */
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// ==============================
// sizes of the padding stage
// ==============================

// lanes in the snake, also the widest kernel supported
`define KERNEL_W_MAX 7

`define KW_WIDTH     3 // holds kernel width minus one

// column counters, rows of up to 256 beats
`define COL_WIDTH    8

`endif

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module conv_pad_tb \
    --Mdir obj_dir \
    -o conv_pad_sim

status=0
./obj_dir/conv_pad_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Test completed successfully" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, exit status $status"
exit 1

/* sources.f */
+incdir+include
design/conv_cfg_pkg.sv
design/conv_stream_pkg.sv
design/conv_cfg_regs.sv
design/col_tagger.sv
design/pad_filter.sv
design/conv_pad_top.sv
tests/conv_pad_tb.sv

/* tests/conv_pad_tb.sv */
`timescale 1ns/100ps
`include "conv_params.svh"

module conv_pad_tb;

    import conv_cfg_pkg::*;

    localparam int NL   = `KERNEL_W_MAX;
    localparam int HIST = 16; // beats remembered by the model, more than the snake holds

    logic                  aclk;
    logic                  rst_n;
    logic                  aclken;
    logic                  cfg_wr;
    cfg_addr_e             cfg_addr;
    logic [7:0]            cfg_wdata;
    logic                  s_valid;
    logic                  s_last;
    logic [NL-1:0]         snake_valid;
    logic [NL-1:0]         m_valid;
    logic [NL-1:0]         m_last;
    logic                  row_err;

    logic [31:0]           lfsr;

    // ==============================
    // reference model state
    // ==============================

    logic [`KW_WIDTH-1:0]  stg_kw_1;   // values written over the register port
    conv_mode_e            stg_mode;
    logic [`COL_WIDTH-1:0] stg_cols_1;
    logic [`KW_WIDTH-1:0]  act_kw_1;   // values taken at the last start
    conv_mode_e            act_mode;
    logic [`COL_WIDTH-1:0] act_cols_1;
    logic                  start_pend;
    logic                  running;
    int                    row_col;
    logic                  err_exp;
    int                    edge_cnt;   // enabled edges since reset
    logic [3:0]            slot;
    logic [HIST-1:0]       hist_v;
    logic [HIST-1:0]       hist_l;
    logic [`COL_WIDTH-1:0] hist_c [HIST];
    logic [`COL_WIDTH-1:0] hist_left [HIST];
    logic [NL-1:0]         exp_snake;
    logic [NL-1:0]         exp_valid;
    logic [NL-1:0]         exp_last;

    conv_pad_top i_dut (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .aclken      (aclken),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .s_valid     (s_valid),
        .s_last      (s_last),
        .snake_valid (snake_valid),
        .m_valid     (m_valid),
        .m_last      (m_last),
        .row_err     (row_err)
    );

    always #5 aclk = ~aclk;

    // every enabled edge gets a history slot, holding the beat taken at that edge
    always @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            stg_kw_1   = 3'd2;
            stg_mode   = MODE_KXK;
            stg_cols_1 = 8'd7;
            act_kw_1   = 3'd2;
            act_mode   = MODE_KXK;
            act_cols_1 = 8'd7;
            start_pend = 1'b0;
            running    = 1'b0;
            row_col    = 0;
            err_exp    = 1'b0;
            edge_cnt   = 0;
            hist_v     = '0;
            hist_l     = '0;
        end else if (aclken) begin
            edge_cnt        = edge_cnt + 1;
            slot            = edge_cnt[3:0];
            hist_v[slot]    = 1'b0;
            hist_l[slot]    = 1'b0;
            hist_c[slot]    = '0;
            hist_left[slot] = '0;
            if (start_pend) begin
                act_kw_1   = stg_kw_1;
                act_mode   = stg_mode;
                act_cols_1 = stg_cols_1;
                running    = 1'b1;
                row_col    = 0;
                err_exp    = 1'b0; // a beat in the start cycle is lost
            end else if (running && s_valid) begin
                hist_v[slot]    = 1'b1;
                hist_l[slot]    = s_last;
                hist_c[slot]    = row_col[`COL_WIDTH-1:0];
                hist_left[slot] = act_cols_1 - row_col[`COL_WIDTH-1:0];
                if (row_col > int'(act_cols_1) || (s_last && row_col != int'(act_cols_1))) begin
                    err_exp = 1'b1;
                end
                row_col = s_last ? 0 : row_col + 1;
            end
            start_pend = cfg_wr && (cfg_addr == ADDR_CTRL) && cfg_wdata[0];
            if (cfg_wr) begin
                case (cfg_addr)
                    ADDR_KERNEL_W_1: stg_kw_1   = cfg_wdata[`KW_WIDTH-1:0];
                    ADDR_MODE:       stg_mode   = conv_mode_e'(cfg_wdata[0]);
                    ADDR_ROW_COLS_1: stg_cols_1 = cfg_wdata;
                    default:         ;
                endcase
            end
        end
    end

    // lane k shows the beat taken k+1 enabled edges ago
    always_comb begin
        int         idx;
        int         pad;
        logic [3:0] rd;
        logic       live;
        pad = (act_mode == MODE_1X1) ? 0 : int'(act_kw_1) / 2;
        for (int k = 0; k < NL; k++) begin
            idx  = edge_cnt - 1 - k;
            rd   = idx[3:0];
            live = (act_mode == MODE_1X1) ? (k == 0) : (k <= int'(act_kw_1));
            if (idx >= 1) begin
                exp_snake[k] = hist_v[rd];
                exp_valid[k] = hist_v[rd] && live &&
                               (k <= int'(hist_c[rd]) + pad) &&
                               (k >= pad - int'(hist_left[rd]));
                exp_last[k]  = hist_l[rd] && live;
            end else begin
                exp_snake[k] = 1'b0;
                exp_valid[k] = 1'b0;
                exp_last[k]  = 1'b0;
            end
        end
    end

    // ==============================
    // checks
    // ==============================

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [NL-1:0] got,
                                   input logic [NL-1:0] exp);
        stop_on_error($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    chk_m_valid: assert property (@(negedge aclk) disable iff (!rst_n) m_valid == exp_valid)
        else report_mismatch("m_valid", m_valid, exp_valid);
    chk_m_last: assert property (@(negedge aclk) disable iff (!rst_n) m_last == exp_last)
        else report_mismatch("m_last", m_last, exp_last);
    chk_snake: assert property (@(negedge aclk) disable iff (!rst_n) snake_valid == exp_snake)
        else report_mismatch("snake_valid", snake_valid, exp_snake);
    chk_row_err: assert property (@(negedge aclk) disable iff (!rst_n) row_err == err_exp)
        else report_mismatch("row_err", NL'(row_err), NL'(err_exp));

    // ==============================
    // stimulus
    // ==============================

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[6:0], lfsr[0]};
        end
    endtask

    task automatic drive_idle(input logic en);
        aclken  = en;
        s_valid = 1'b0;
        s_last  = 1'b0;
        cfg_wr  = 1'b0;
    endtask

    task automatic idle_random(input int n);
        logic [7:0] b;
        repeat (n) begin
            @(negedge aclk);
            take_bits(1, b);
            drive_idle(b[0]);
        end
    endtask

    // holds the beat until an enabled edge takes it, wr adds a kernel width rewrite
    task automatic send_beat(input logic last, input logic wr);
        logic [7:0] en;
        int         tries;
        tries = 0;
        en    = '0;
        while (en[0] == 1'b0 && tries < 32) begin
            @(negedge aclk);
            take_bits(1, en);
            aclken    = en[0];
            s_valid   = 1'b1;
            s_last    = last;
            cfg_wr    = wr;
            cfg_addr  = ADDR_KERNEL_W_1;
            cfg_wdata = 8'd6;
            tries++;
            @(posedge aclk);
        end
        if (en[0] == 1'b0) stop_on_error("a beat was not taken within 32 cycles");
    endtask

    task automatic send_row(input int n_beats, input int wr_at);
        logic [7:0] gap;
        take_bits(3, gap);
        idle_random(int'(gap));
        for (int i = 0; i < n_beats; i++) begin
            send_beat(i == n_beats - 1, i == wr_at);
        end
    endtask

    task automatic write_reg(input cfg_addr_e addr, input logic [7:0] data);
        @(negedge aclk);
        drive_idle(1'b1);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge aclk);
    endtask

    task automatic start_rows();
        write_reg(ADDR_CTRL, 8'h01);
        @(negedge aclk);
        drive_idle(1'b1);
        @(posedge aclk); // shadow loads here
        @(negedge aclk);
        drive_idle(1'b1);
        chk_err_clear: assert (row_err == 1'b0)
            else report_mismatch("row_err", NL'(row_err), '0);
    endtask

    task automatic configure(input int kernel_w, input conv_mode_e mode, input int cols);
        write_reg(ADDR_KERNEL_W_1, 8'(kernel_w - 1));
        write_reg(ADDR_MODE, {7'd0, mode});
        write_reg(ADDR_ROW_COLS_1, 8'(cols - 1));
        start_rows();
    endtask

    task automatic drain();
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < NL + 2 && cycles < 64) begin
            @(negedge aclk);
            drive_idle(1'b1);
            quiet = (snake_valid == '0) ? quiet + 1 : 0;
            cycles++;
        end
        if (quiet < NL + 2) stop_on_error("the lane snake did not drain within 64 cycles");
    endtask

    task automatic wait_row_err();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 20) begin
            @(negedge aclk);
            drive_idle(1'b1);
            seen = row_err;
            cycles++;
        end
        if (!seen) stop_on_error("row_err did not rise after a malformed row");
    endtask

    initial begin
        aclk      = 1'b0;
        rst_n     = 1'b0;
        aclken    = 1'b0;
        cfg_wr    = 1'b0;
        cfg_addr  = ADDR_KERNEL_W_1;
        cfg_wdata = 8'h00;
        s_valid   = 1'b0;
        s_last    = 1'b0;
        lfsr      = 32'he7b3;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;

        send_row(8, -1); // no start yet, all of it is dropped
        drain();
        configure(3, MODE_KXK, 8);
        repeat (4) send_row(8, -1);
        drain();
        configure(5, MODE_KXK, 8);
        repeat (3) send_row(8, -1);
        drain();
        configure(7, MODE_KXK, 12);
        repeat (3) send_row(12, -1);
        drain();
        configure(3, MODE_1X1, 6);
        repeat (3) send_row(6, -1);
        drain();

        // kernel width rewritten in mid-row, used only after the next start
        configure(3, MODE_KXK, 8);
        send_row(8, 3);
        send_row(8, -1);
        drain();
        start_rows();
        send_row(8, -1);
        drain();

        send_row(5, -1);
        wait_row_err();
        start_rows();
        send_row(8, -1);
        send_row(10, -1);
        wait_row_err();
        start_rows();
        send_row(8, -1);
        drain();

        $display("Test completed successfully");
        $finish;
    end

endmodule
